//--- bench/tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

module tb_bridge;

    localparam int NUM_ROWS  = 24;
    localparam int WD_CYCLES = NUM_ROWS * 4 * 50 + 10;  // rows x flits x 50, plus reset

    typedef struct {
        bridge_pkg::req_kind_e     kind;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_DATA_W-1:0] data;
        logic [`BRIDGE_STRB_W-1:0] strb;
        bit                        pair;    // W first, then AW and AR together
        bit                        rnd;     // random noc_ready while this row runs
    } row_t;

    logic                        clk;
    logic                        rst_n;
    logic [`BRIDGE_ADDR_W-1:0]   awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`BRIDGE_DATA_W-1:0]   wdata;
    logic [`BRIDGE_STRB_W-1:0]   wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [`BRIDGE_ADDR_W-1:0]   araddr;
    logic                        arvalid;
    logic                        arready;
    logic                        noc_valid;
    logic [`BRIDGE_DATA_W-1:0]   noc_data;
    logic                        noc_ready;
    logic [`BRIDGE_CHIPID_W-1:0] src_chipid;
    logic [`BRIDGE_X_W-1:0]      src_x;
    logic [`BRIDGE_Y_W-1:0]      src_y;
    logic [`BRIDGE_FBITS_W-1:0]  src_fbits;
    logic [`BRIDGE_CHIPID_W-1:0] dst_chipid;
    logic [`BRIDGE_X_W-1:0]      dst_x;
    logic [`BRIDGE_Y_W-1:0]      dst_y;
    logic [`BRIDGE_FBITS_W-1:0]  dst_fbits;

    row_t                      rows [NUM_ROWS];
    logic [`BRIDGE_DATA_W-1:0] exp_q [$];       // expected flits in acceptance order
    logic [`BRIDGE_DATA_W-1:0] stall_data;
    logic [`BRIDGE_DATA_W-1:0] exp_flit;
    bit                        rnd_ready;
    bit                        was_stalled;
    bit                        saw_full;        // every AXI ready dropped with the order fifo full
    int                        value_errs;
    int                        flit_errs;
    int                        other_errs;

    axilite_noc_bridge dut0 (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .noc_valid(noc_valid), .noc_data(noc_data), .noc_ready(noc_ready),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .dst_chipid(dst_chipid), .dst_x(dst_x), .dst_y(dst_y), .dst_fbits(dst_fbits)
    );

    always #50 clk = ~clk;

    // flit idx of a packet, 3 is the data flit of a store
    function automatic logic [63:0] expected_flit(input bit is_store, input logic [39:0] addr,
            input logic [63:0] data, input logic [7:0] strb, input int idx);
        logic [63:0] f;
        logic [7:0]  rstrb;
        f = '0;
        for (int b = 0; b < 8; b++) rstrb[b] = strb[7-b];
        case (idx)
            0: begin
                f[`BRIDGE_F1_DST_CHIPID] = dst_chipid;
                f[`BRIDGE_F1_DST_X]      = dst_x;
                f[`BRIDGE_F1_DST_Y]      = dst_y;
                f[`BRIDGE_F1_DST_FBITS]  = dst_fbits;
                f[`BRIDGE_F1_LENGTH]     = is_store ? 8'd3 : 8'd2;
                f[`BRIDGE_F1_MSG_TYPE]   = is_store ? bridge_pkg::NC_STORE_REQ
                                                    : bridge_pkg::NC_LOAD_REQ;
            end
            1: begin
                f[`BRIDGE_F2_ADDR]      = addr;
                f[`BRIDGE_F2_DATA_SIZE] = bridge_pkg::SIZE_8B;
                f[`BRIDGE_F2_MASK0]     = (is_store && !addr[3]) ? rstrb : 8'h00;
            end
            2: begin
                f[`BRIDGE_F3_SRC_CHIPID] = src_chipid;
                f[`BRIDGE_F3_SRC_X]      = src_x;
                f[`BRIDGE_F3_SRC_Y]      = src_y;
                f[`BRIDGE_F3_SRC_FBITS]  = src_fbits;
                f[`BRIDGE_F3_MASK1]      = (is_store && addr[3]) ? rstrb : 8'h00;
            end
            default: begin
                for (int b = 0; b < 8; b++) f[8*b +: 8] = data[8*(7-b) +: 8];
            end
        endcase
        return f;
    endfunction

    task automatic queue_packet(input bit is_store, input logic [39:0] addr,
            input logic [63:0] data, input logic [7:0] strb);
        int n;
        n = is_store ? 4 : 3;
        for (int i = 0; i < n; i++) exp_q.push_back(expected_flit(is_store, addr, data, strb, i));
    endtask

    // raise valids, wait for each channel's handshake, note acceptance order
    task automatic apply_row(input row_t r);
        bit aw_pend;
        bit w_pend;
        bit ar_pend;
        bit aw_go;
        bit w_go;
        bit ar_go;
        rnd_ready = r.rnd;
        aw_pend   = (r.kind == bridge_pkg::STORE);
        w_pend    = aw_pend;
        ar_pend   = (r.kind == bridge_pkg::LOAD) || r.pair;
        awaddr    = r.addr;
        araddr    = r.pair ? r.addr + 40'h40 : r.addr;
        wdata     = r.data;
        wstrb     = r.strb;
        while (aw_pend || w_pend || ar_pend) begin
            wvalid  = w_pend;
            awvalid = aw_pend && !(r.pair && w_pend);
            arvalid = ar_pend && !(r.pair && w_pend);
            @(negedge clk);
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            ar_go = arvalid && arready;
            if (aw_go) queue_packet(1'b1, r.addr, r.data, r.strb);    // store ahead of a paired load
            if (ar_go) queue_packet(1'b0, araddr, '0, '0);
            @(posedge clk);
            #1;
            if (aw_go) aw_pend = 1'b0;
            if (w_go) w_pend = 1'b0;
            if (ar_go) ar_pend = 1'b0;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    endtask

    task automatic build_table();
        rows[0] = '{bridge_pkg::LOAD,  40'h00_1234_5670, 64'h0, 8'h00, 1'b0, 1'b0};
        rows[1] = '{bridge_pkg::STORE, 40'h00_0000_1000, 64'h0102_0304_0506_0708, 8'h0f,
                    1'b0, 1'b0};
        rows[2] = '{bridge_pkg::STORE, 40'h00_0000_2008, 64'hdead_beef_cafe_f00d, 8'hc1,
                    1'b0, 1'b0};
        rows[3] = '{bridge_pkg::STORE, 40'h00_0000_3010, 64'h1122_3344_5566_7788, 8'hff,
                    1'b1, 1'b0};
        for (int i = 4; i < NUM_ROWS; i++) begin
            rows[i].kind = ($urandom() % 2 == 0) ? bridge_pkg::LOAD : bridge_pkg::STORE;
            rows[i].addr = {8'h00, $urandom()};
            rows[i].data = {$urandom(), $urandom()};
            rows[i].strb = 8'($urandom());
            rows[i].pair = 1'b0;
            rows[i].rnd  = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (rnd_ready) noc_ready = ($urandom() % 3 == 0);
        else noc_ready = 1'b1;
    end

    // flit monitor, samples at the falling edge where every signal is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (was_stalled) begin
                assert (noc_valid) else begin
                    $display("Error: noc_valid under stall expected %h got %h", 1'b1, noc_valid);
                    flit_errs++;
                end
                assert (noc_data == stall_data) else begin
                    $display("Error: noc_data changed under stall, expected %h got %h",
                             stall_data, noc_data);
                    value_errs++;
                end
            end
            was_stalled = noc_valid && !noc_ready;
            stall_data  = noc_data;
            // a parked read drops only awready and arready, a full order fifo drops all three
            if (rnd_ready && !awready && !wready && !arready) saw_full = 1'b1;
            if (noc_valid && noc_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("extra flit %h arrived with no packet outstanding", noc_data);
                    flit_errs++;
                end
                if (exp_q.size() != 0) begin
                    exp_flit = exp_q.pop_front();
                    assert (noc_data == exp_flit) else begin
                        $display("Error: noc_data expected %h got %h", exp_flit, noc_data);
                        value_errs++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: %0d expected flits never arrived", exp_q.size());
        $display("errors: %0d value, %0d flit, %0d other", value_errs, flit_errs, other_errs);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h00cedd0a));
        clk        = 1'b0;
        rst_n      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        noc_ready  = 1'b1;
        src_chipid = 14'h0123;
        src_x      = 8'h05;
        src_y      = 8'h0a;
        src_fbits  = 4'h3;
        dst_chipid = 14'h2abc;
        dst_x      = 8'h71;
        dst_y      = 8'h2e;
        dst_fbits  = 4'hc;
        build_table();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        assert (noc_valid == 1'b0) else begin
            $display("Error: noc_valid expected %h got %h", 1'b0, noc_valid);
            value_errs++;
        end
        assert (awready && wready && arready) else begin
            $display("Error: awready/wready/arready expected %h got %h", 3'b111,
                     {awready, wready, arready});
            value_errs++;
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ROWS; i++) apply_row(rows[i]);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        assert (!noc_valid) else begin
            $display("noc_valid still high after the last expected flit");
            flit_errs++;
        end
        assert (saw_full) else begin
            $display("AXI ready outputs never dropped under NoC back-pressure");
            other_errs++;
        end
        $display("errors: %0d value, %0d flit, %0d other", value_errs, flit_errs, other_errs);
        if (value_errs + flit_errs + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- include/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// axi side widths
`define BRIDGE_ADDR_W        40     // also the physical address width
`define BRIDGE_DATA_W        64
`define BRIDGE_STRB_W        8
`define BRIDGE_FIFO_DEPTH    16

// routing field widths
`define BRIDGE_CHIPID_W      14
`define BRIDGE_X_W           8
`define BRIDGE_Y_W           8
`define BRIDGE_FBITS_W       4

// packet shape
`define BRIDGE_HDR_FLITS     3
`define BRIDGE_LEN_LOAD      8'd2   // flits after the first header
`define BRIDGE_LEN_STORE     8'd3
`define BRIDGE_WORD_SEL_BIT  3      // picks mask0 or mask1

// header flit 1, bits 13:0 stay zero
`define BRIDGE_F1_DST_CHIPID 63:50
`define BRIDGE_F1_DST_X      49:42
`define BRIDGE_F1_DST_Y      41:34
`define BRIDGE_F1_DST_FBITS  33:30
`define BRIDGE_F1_LENGTH     29:22
`define BRIDGE_F1_MSG_TYPE   21:14

// header flit 2
`define BRIDGE_F2_ADDR       63:24
`define BRIDGE_F2_DATA_SIZE  23:16
`define BRIDGE_F2_MASK0      15:8

// header flit 3
`define BRIDGE_F3_SRC_CHIPID 63:50
`define BRIDGE_F3_SRC_X      49:42
`define BRIDGE_F3_SRC_Y      41:34
`define BRIDGE_F3_SRC_FBITS  33:30
`define BRIDGE_F3_MASK1      29:22

`endif

//--- list.f
+incdir+include
src/bridge_pkg.sv
src/sync_fifo.sv
src/bridge_req_if.sv
src/axi_req_capture.sv
src/flit_sequencer.sv
src/axilite_noc_bridge.sv
bench/tb_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_bridge \
    -Mdir obj_dir -o sim_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "sim passed" "$LOG"
if [ $? -ne 0 ]; then
    echo "pass message not found in $LOG"
    exit 1
fi

exit 0

//--- src/axi_req_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

module axi_req_capture (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`BRIDGE_ADDR_W-1:0]  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`BRIDGE_DATA_W-1:0]  wdata,
    input  logic [`BRIDGE_STRB_W-1:0]  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`BRIDGE_ADDR_W-1:0]  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    bridge_req_if.capture              req
);

    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic read_parked;          // read accepted together with a write, kind not yet queued

    bridge_pkg::req_kind_e ord_wr_kind;
    logic                  ord_wr;
    logic [1:0]            ord_head;
    logic                  ord_full;
    logic                  ord_empty;

    logic [`BRIDGE_ADDR_W-1:0] aw_head;
    logic                      aw_full;
    logic                      aw_empty;
    logic [`BRIDGE_DATA_W-1:0] w_head;
    logic                      w_full;
    logic                      w_empty;
    logic [`BRIDGE_STRB_W-1:0] strb_head;
    logic                      strb_full;
    logic                      strb_empty;
    logic [`BRIDGE_ADDR_W-1:0] ar_head;
    logic                      ar_full;
    logic                      ar_empty;

    logic pop_store;
    logic pop_load;

    assign awready = !aw_full && !ord_full && !read_parked;
    assign wready  = !w_full && !strb_full && !ord_full;
    assign arready = !ar_full && !ord_full && !read_parked;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // a simultaneous pair queues STORE now and LOAD one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_parked <= 1'b0;
        end else if (aw_fire && ar_fire) begin
            read_parked <= 1'b1;
        end else if (read_parked && !ord_full) begin
            read_parked <= 1'b0;
        end
    end

    assign ord_wr      = aw_fire || ar_fire || (read_parked && !ord_full);
    assign ord_wr_kind = aw_fire ? bridge_pkg::STORE : bridge_pkg::LOAD;

    sync_fifo #(.WIDTH(2), .DEPTH(`BRIDGE_FIFO_DEPTH)) order_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(ord_wr), .wr_data(ord_wr_kind), .full(ord_full),
        .rd_en(req.done), .rd_data(ord_head), .empty(ord_empty)
    );

    sync_fifo #(.WIDTH(`BRIDGE_ADDR_W), .DEPTH(`BRIDGE_FIFO_DEPTH)) aw_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(aw_fire), .wr_data(awaddr), .full(aw_full),
        .rd_en(pop_store), .rd_data(aw_head), .empty(aw_empty)
    );

    sync_fifo #(.WIDTH(`BRIDGE_DATA_W), .DEPTH(`BRIDGE_FIFO_DEPTH)) w_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(w_fire), .wr_data(wdata), .full(w_full),
        .rd_en(pop_store), .rd_data(w_head), .empty(w_empty)
    );

    sync_fifo #(.WIDTH(`BRIDGE_STRB_W), .DEPTH(`BRIDGE_FIFO_DEPTH)) strb_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(w_fire), .wr_data(wstrb), .full(strb_full),
        .rd_en(pop_store), .rd_data(strb_head), .empty(strb_empty)
    );

    sync_fifo #(.WIDTH(`BRIDGE_ADDR_W), .DEPTH(`BRIDGE_FIFO_DEPTH)) ar_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(ar_fire), .wr_data(araddr), .full(ar_full),
        .rd_en(pop_load), .rd_data(ar_head), .empty(ar_empty)
    );

    assign pop_store = req.done && (req.kind == bridge_pkg::STORE);
    assign pop_load  = req.done && (req.kind == bridge_pkg::LOAD);

    always_comb begin
        req.kind = ord_empty ? bridge_pkg::NONE : bridge_pkg::req_kind_e'(ord_head);
        case (req.kind)
            bridge_pkg::STORE: begin
                req.ready_req = !aw_empty && !w_empty && !strb_empty;
                req.addr      = aw_head;
            end
            bridge_pkg::LOAD: begin
                req.ready_req = !ar_empty;
                req.addr      = ar_head;
            end
            default: begin
                req.ready_req = 1'b0;
                req.addr      = '0;
            end
        endcase
    end

    // noc expects big-endian byte order
    assign req.wdata = {<<8{w_head}};
    assign req.strb  = {<<1{strb_head}};

    // the sequencer may only finish a packet for a complete head request
    a_done_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        req.done |-> req.ready_req)
        else $error("axi_req_capture: done without a complete head request");

endmodule

`default_nettype wire

//--- src/axilite_noc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

module axilite_noc_bridge (
    input  logic                        clk,
    input  logic                        rst_n,
    // aw channel
    input  logic [`BRIDGE_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    // w channel
    input  logic [`BRIDGE_DATA_W-1:0]   wdata,
    input  logic [`BRIDGE_STRB_W-1:0]   wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    // ar channel
    input  logic [`BRIDGE_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    // noc request output
    output logic                        noc_valid,
    output logic [`BRIDGE_DATA_W-1:0]   noc_data,
    input  logic                        noc_ready,
    // static routing
    input  logic [`BRIDGE_CHIPID_W-1:0] src_chipid,
    input  logic [`BRIDGE_X_W-1:0]      src_x,
    input  logic [`BRIDGE_Y_W-1:0]      src_y,
    input  logic [`BRIDGE_FBITS_W-1:0]  src_fbits,
    input  logic [`BRIDGE_CHIPID_W-1:0] dst_chipid,
    input  logic [`BRIDGE_X_W-1:0]      dst_x,
    input  logic [`BRIDGE_Y_W-1:0]      dst_y,
    input  logic [`BRIDGE_FBITS_W-1:0]  dst_fbits
);

    bridge_req_if req_if ();    // capture to sequencer

    axi_req_capture capture0 (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .req(req_if.capture)
    );

    flit_sequencer seq0 (
        .clk(clk), .rst_n(rst_n),
        .req(req_if.sequencer),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .dst_chipid(dst_chipid), .dst_x(dst_x), .dst_y(dst_y), .dst_fbits(dst_fbits),
        .noc_valid(noc_valid), .noc_data(noc_data), .noc_ready(noc_ready)
    );

endmodule

`default_nettype wire

//--- src/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // what sits at the head of the order fifo
    typedef enum logic [1:0] {
        NONE  = 2'd0,   // order fifo empty
        LOAD  = 2'd1,
        STORE = 2'd2
    } req_kind_e;

    // output sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        HEADER = 2'd1,  // three header flits
        DATA   = 2'd2   // one data flit, stores only
    } flit_state_e;

    // noc message opcodes carried in header flit 1
    typedef enum logic [7:0] {
        NC_LOAD_REQ  = 8'd14,
        NC_STORE_REQ = 8'd15
    } msg_type_e;

    // size code in header flit 2
    typedef enum logic [7:0] {
        SIZE_8B = 8'd4
    } data_size_e;

endpackage

`default_nettype wire

//--- src/bridge_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

// head request handed from the capture stage to the flit sequencer
interface bridge_req_if;

    bridge_pkg::req_kind_e      kind;       // head of the order fifo
    logic                       ready_req;  // all fifos for that kind hold an entry
    logic [`BRIDGE_ADDR_W-1:0]  addr;
    logic [`BRIDGE_DATA_W-1:0]  wdata;      // byte reversed
    logic [`BRIDGE_STRB_W-1:0]  strb;       // bit reversed
    logic                       done;       // last flit handshake, pops the head

    modport capture (
        output kind, ready_req, addr, wdata, strb,
        input  done
    );

    modport sequencer (
        input  kind, ready_req, addr, wdata, strb,
        output done
    );

endinterface

`default_nettype wire

//--- src/flit_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

module flit_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    bridge_req_if.sequencer             req,
    input  logic [`BRIDGE_CHIPID_W-1:0] src_chipid,
    input  logic [`BRIDGE_X_W-1:0]      src_x,
    input  logic [`BRIDGE_Y_W-1:0]      src_y,
    input  logic [`BRIDGE_FBITS_W-1:0]  src_fbits,
    input  logic [`BRIDGE_CHIPID_W-1:0] dst_chipid,
    input  logic [`BRIDGE_X_W-1:0]      dst_x,
    input  logic [`BRIDGE_Y_W-1:0]      dst_y,
    input  logic [`BRIDGE_FBITS_W-1:0]  dst_fbits,
    output logic                        noc_valid,
    output logic [`BRIDGE_DATA_W-1:0]   noc_data,
    input  logic                        noc_ready
);

    bridge_pkg::flit_state_e state;
    logic [1:0]              cnt;           // header flit index
    logic                    is_store;
    logic                    word_sel;
    logic                    flit_fire;
    logic                    last_hdr;
    logic [`BRIDGE_DATA_W-1:0] flit;

    assign is_store  = (req.kind == bridge_pkg::STORE);
    assign word_sel  = req.addr[`BRIDGE_WORD_SEL_BIT];
    assign noc_valid = (state != bridge_pkg::IDLE);
    assign flit_fire = noc_valid && noc_ready;
    assign last_hdr  = (cnt == 2'(`BRIDGE_HDR_FLITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bridge_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                bridge_pkg::IDLE: begin
                    if (req.ready_req) begin
                        state <= bridge_pkg::HEADER;
                        cnt   <= '0;
                    end
                end
                bridge_pkg::HEADER: begin
                    if (flit_fire && last_hdr) begin
                        state <= is_store ? bridge_pkg::DATA : bridge_pkg::IDLE;
                        cnt   <= '0;
                    end else if (flit_fire) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                bridge_pkg::DATA: begin
                    if (flit_fire) state <= bridge_pkg::IDLE;
                end
                default: state <= bridge_pkg::IDLE;
            endcase
        end
    end

    // a load ends on its third header, a store on its data flit
    assign req.done = flit_fire &&
                      ((state == bridge_pkg::DATA) ||
                       (state == bridge_pkg::HEADER && last_hdr && !is_store));

    always_comb begin
        flit = '0;
        case (state)
            bridge_pkg::HEADER: begin
                case (cnt)
                    2'd0: begin
                        flit[`BRIDGE_F1_DST_CHIPID] = dst_chipid;
                        flit[`BRIDGE_F1_DST_X]      = dst_x;
                        flit[`BRIDGE_F1_DST_Y]      = dst_y;
                        flit[`BRIDGE_F1_DST_FBITS]  = dst_fbits;
                        flit[`BRIDGE_F1_LENGTH]     = is_store ? `BRIDGE_LEN_STORE
                                                               : `BRIDGE_LEN_LOAD;
                        flit[`BRIDGE_F1_MSG_TYPE]   = is_store ? bridge_pkg::NC_STORE_REQ
                                                               : bridge_pkg::NC_LOAD_REQ;
                    end
                    2'd1: begin
                        flit[`BRIDGE_F2_ADDR]      = req.addr;
                        flit[`BRIDGE_F2_DATA_SIZE] = bridge_pkg::SIZE_8B;
                        flit[`BRIDGE_F2_MASK0]     = (is_store && !word_sel) ? req.strb : '0;
                    end
                    default: begin
                        flit[`BRIDGE_F3_SRC_CHIPID] = src_chipid;
                        flit[`BRIDGE_F3_SRC_X]      = src_x;
                        flit[`BRIDGE_F3_SRC_Y]      = src_y;
                        flit[`BRIDGE_F3_SRC_FBITS]  = src_fbits;
                        flit[`BRIDGE_F3_MASK1]      = (is_store && word_sel) ? req.strb : '0;
                    end
                endcase
            end
            bridge_pkg::DATA: flit = req.wdata;
            default: flit = '0;
        endcase
    end

    assign noc_data = flit;

    // a stalled flit must not change, which needs the head request held until done
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_valid && !noc_ready) |=> (noc_valid && $stable(noc_data)))
        else $error("flit_sequencer: flit changed while stalled");

endmodule

`default_nettype wire

//--- src/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// circular buffer, head entry always visible on rd_data
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // entries held

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or one in and one out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= wr_data;
    end

    assign rd_data = mem[rd_ptr];   // show-ahead
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);

    // the producer and consumer are expected to look at full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !wr_en)
        else $error("sync_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !rd_en)
        else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire
